// ==== filelist.f ====
+incdir+logic
logic/fetch_pkg.sv
logic/instr_mem.sv
logic/fetch_stage.sv
logic/branch_predecode.sv
logic/fetch_queue.sv
logic/fetch_frontend.sv
tb/fetch_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the fetch front end testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --assert --top-module fetch_tb -f filelist.f \
  -Mdir "$BUILD_DIR" -o fetch_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

"./$BUILD_DIR/fetch_sim" > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
  echo "simulation exited with status $run_status"
  exit 1
fi

if grep -q '^\*\*\* PASSED \*\*\*$' "$LOG"; then
  echo "result: pass"
  exit 0
else
  echo "result: fail"
  exit 1
fi

// ==== tb/fetch_tb.sv ====
// self-checking testbench; the 20-word program must fit the 10 reset cycles, one line loaded per cycle
`default_nettype none

`include "fetch_params.svh"

module fetch_tb;

  localparam int AW          = $clog2(`IMEM_LINES);
  localparam int PROG_WORDS  = 20;              // 10 lines, all loaded during reset
  localparam int MIN_XFERS   = 600;             // transfers needed before passing
  localparam int CYCLE_LIMIT = 4000;            // 600 at a worst case near 0.3 per cycle, doubled

  logic                 clock;
  logic                 reset;
  logic                 load_en;
  logic [AW-1:0]        load_addr;
  fetch_pkg::line_t     load_data;
  logic                 redirect_valid;
  fetch_pkg::pc_t       redirect_pc;
  logic                 out_ready;
  logic                 out_valid;
  fetch_pkg::inst_t     out_inst;
  fetch_pkg::pc_t       out_pc;

  fetch_pkg::inst_t     prog [PROG_WORDS];      // testbench copy of the program
  integer               seed = 27364;
  int                   cycles = 0;             // timeout counter
  int                   transfers;              // checked outputs so far
  fetch_pkg::pc_t       exp_pc;                 // next pc the stream must show
  logic                 held;                   // head stalled last edge
  fetch_pkg::inst_t     held_inst;
  fetch_pkg::pc_t       held_pc;

  fetch_frontend uut (
    .clock, .reset, .load_en, .load_addr, .load_data,
    .redirect_valid, .redirect_pc, .out_ready,
    .out_valid, .out_inst, .out_pc
  );

  ////////////////////
  // encodings and reference
  ////////////////////

  function automatic fetch_pkg::inst_t alu_word(input int tag);
    return {fetch_pkg::op_alu, 5'd0, 21'(tag)};      // tag makes each word unique
  endfunction

  function automatic fetch_pkg::inst_t jump_word(input int disp);
    return {fetch_pkg::op_jump, 5'd0, 21'(disp)};
  endfunction

  function automatic fetch_pkg::inst_t branch_word(input int disp);
    return {fetch_pkg::op_branch, 5'd0, 21'(disp)};
  endfunction

  // pc of the instruction delivered after the one at pc; per instruction,
  // which matches the line rule since a taken slot 0 kills slot 1
  function automatic fetch_pkg::pc_t next_fetch_pc(input fetch_pkg::pc_t pc);
    fetch_pkg::inst_t inst;
    logic [5:0]       opc;
    logic [20:0]      disp;
    int               disp_words;
    logic             taken;
    fetch_pkg::pc_t   target;
    inst       = prog[pc[6:2]];
    opc        = inst[31:26];
    disp       = inst[20:0];
    disp_words = int'($signed(disp));
    taken      = (opc == fetch_pkg::op_jump) || ((opc == fetch_pkg::op_branch) && disp[20]);
    target     = pc + 64'(4 * (disp_words + 1));   // disp words past pc + 4
    return taken ? target : pc + 64'd4;
  endfunction

  // prints the cause, then the fail message, then stops
  task automatic fail_run(input string what);
    $display("%s", what);
    $display("*** FAILED ***");
    $fatal(1, "simulation stopped on first error");
  endtask

  // main loop 0,1,2,3,4,7,8,9,12,16,14,15,18,19 then back to 0
  task automatic build_program();
    for (int k = 0; k < PROG_WORDS; k++)
      prog[k] = alu_word(k);
    prog[2]  = branch_word(1);      // forward, slot 0, falls through
    prog[3]  = branch_word(2);      // forward, slot 1, falls through
    prog[4]  = jump_word(2);        // slot 0 jump to word 7, upper word only
    prog[9]  = jump_word(2);        // slot 1 jump to 12
    prog[12] = jump_word(3);        // slot 0 jump to 16, word 13 dropped
    prog[15] = jump_word(2);        // slot 1 jump to 18
    prog[16] = branch_word(-3);     // backward slot 0 to 14, word 17 dropped
    prog[19] = branch_word(-20);    // backward slot 1 to 0
  endtask

  ////////////////////
  // clock
  ////////////////////

  initial
  begin
    clock = 1'b0;
    forever #10 clock = ~clock;
  end

  ////////////////////
  // stimulus
  ////////////////////

  initial
  begin
    logic [31:0] rnd;
    logic [31:0] rnd_pc;
    int          t;
    build_program();
    reset          = 1'b1;
    redirect_valid = 1'b0;
    redirect_pc    = '0;
    out_ready      = 1'b0;
    load_en        = 1'b1;                         // line 0 goes in at the first edge
    load_addr      = '0;
    load_data      = {prog[1], prog[0]};
    for (int i = 1; i < PROG_WORDS / 2; i++)
    begin
      @(posedge clock);
      load_addr <= AW'(i);
      load_data <= {prog[2*i+1], prog[2*i]};       // slot 0 in the low word
    end
    @(posedge clock);                              // 10th edge with reset high
    load_en <= 1'b0;
    reset   <= 1'b0;
    t = 0;
    forever
    begin
      @(posedge clock);
      t++;
      rnd    = $random(seed);
      rnd_pc = $random(seed);
      // redirect now and then after the first clean passes, and always at the end of a full queue
      if (((t > 150) && (rnd % 32'd40 == 32'd0)) || (t % 200 == 179))
      begin
        redirect_valid <= 1'b1;
        redirect_pc    <= {32'd0, (rnd_pc % 32'd20) * 32'd4};
        out_ready      <= 1'b0;                    // no transfer on a flush edge
      end
      else
      begin
        redirect_valid <= 1'b0;
        if ((t % 200) >= 140 && (t % 200) < 179)
          out_ready <= 1'b0;                       // long back-pressure window
        else
          out_ready <= ((rnd_pc % 32'd100) < 32'd70);
      end
    end
  end

  ////////////////////
  // checker
  ////////////////////

  always @(posedge clock)
  begin
    cycles++;
    if (reset)
    begin
      exp_pc    = '0;                              // stream starts at pc 0
      transfers = 0;
      held      = 1'b0;
    end
    else
    begin
      if (held)
      begin
        assert (out_inst == held_inst)
          else fail_run($sformatf("error: out_inst = 0x%h, held 0x%h", out_inst, held_inst));
        assert (out_pc == held_pc)
          else fail_run($sformatf("error: out_pc = 0x%h, held 0x%h", out_pc, held_pc));
      end
      if (out_valid && out_ready)
      begin
        assert (out_pc == exp_pc)
          else fail_run($sformatf("error: out_pc = 0x%h, expected 0x%h", out_pc, exp_pc));
        assert (out_inst == prog[exp_pc[6:2]])
          else fail_run($sformatf("error: out_inst = 0x%h, expected 0x%h",
                                  out_inst, prog[exp_pc[6:2]]));
        exp_pc = next_fetch_pc(exp_pc);
        transfers++;
      end
      held      = out_valid && !out_ready && !redirect_valid;
      held_inst = out_inst;
      held_pc   = out_pc;
      if (redirect_valid)
        exp_pc = redirect_pc;                      // older entries are gone
    end
    if (transfers >= MIN_XFERS)
    begin
      $display("*** PASSED ***");
      $finish;
    end
    else if (cycles >= CYCLE_LIMIT)
      fail_run("timeout: the required number of transfers was not reached in time");
  end

endmodule

`default_nettype wire

// ==== logic/fetch_frontend.sv ====
// top of the fetch front end; load the program before releasing reset, redirect wins over all
`default_nettype none

`include "fetch_params.svh"

module fetch_frontend (
  input  wire logic                           clock,
  input  wire logic                           reset,
  input  wire logic                           load_en,
  input  wire logic [$clog2(`IMEM_LINES)-1:0] load_addr,
  input  wire fetch_pkg::line_t               load_data,
  input  wire logic                           redirect_valid,
  input  wire fetch_pkg::pc_t                 redirect_pc,
  input  wire logic                           out_ready,
  output logic                                out_valid,
  output fetch_pkg::inst_t                    out_inst,
  output fetch_pkg::pc_t                      out_pc
);

  ////////////////////
  // internal nets
  ////////////////////

  fetch_pkg::pc_t   mem_addr;
  fetch_pkg::line_t mem_data;
  logic             mem_valid;

  fetch_pkg::inst_t inst0, inst1;       // aligned slots
  fetch_pkg::pc_t   pc0, pc1;
  logic             slot1_live;

  logic             pred_taken0, pred_taken1;
  fetch_pkg::pc_t   pred_target0, pred_target1;

  logic             push_valid0, push_valid1;
  logic             stall;              // queue back-pressure

  ////////////////////
  // blocks
  ////////////////////

  instr_mem u_imem (
    .clock, .reset, .load_en, .load_addr, .load_data,
    .mem_addr, .mem_data, .mem_valid
  );

  fetch_stage u_fetch (
    .clock, .reset, .stall, .redirect_valid, .redirect_pc,
    .mem_data, .mem_valid,
    .pred_taken0, .pred_taken1, .pred_target0, .pred_target1,
    .mem_addr, .inst0, .inst1, .pc0, .pc1, .slot1_live,
    .push_valid0, .push_valid1
  );

  // combinational loop-free: depends only on pc and line data
  branch_predecode u_predecode (
    .inst0, .inst1, .pc0, .pc1, .slot1_live,
    .pred_taken0, .pred_taken1, .pred_target0, .pred_target1
  );

  fetch_queue #(.DEPTH(`QUEUE_DEPTH)) u_queue (
    .clock, .reset,
    .flush      (redirect_valid),       // stale entries and this cycle's pushes dropped
    .push_valid0, .push_valid1,
    .push_inst0 (inst0),
    .push_inst1 (inst1),
    .push_pc0   (pc0),
    .push_pc1   (pc1),
    .out_ready, .out_valid, .out_inst, .out_pc, .stall
  );

endmodule

`default_nettype wire

// ==== logic/fetch_queue.sv ====
// circular fetch queue; takes two per cycle in slot order, gives one, DEPTH a power of two
`default_nettype none

`include "fetch_params.svh"

module fetch_queue #(
  parameter int DEPTH = `QUEUE_DEPTH
) (
  input  wire logic             clock,
  input  wire logic             reset,
  input  wire logic             flush,         // redirect drops everything
  input  wire logic             push_valid0,
  input  wire logic             push_valid1,
  input  wire fetch_pkg::inst_t push_inst0,
  input  wire fetch_pkg::inst_t push_inst1,
  input  wire fetch_pkg::pc_t   push_pc0,
  input  wire fetch_pkg::pc_t   push_pc1,
  input  wire logic             out_ready,
  output logic                  out_valid,
  output fetch_pkg::inst_t      out_inst,
  output fetch_pkg::pc_t        out_pc,
  output logic                  stall
);

  localparam int PW = $clog2(DEPTH);    // pointer width
  localparam int CW = PW + 1;           // count reaches DEPTH
  localparam logic [CW-1:0] STALL_AT = CW'(DEPTH - 2);

  fetch_pkg::qslot_t slots [DEPTH];     // payload only, no reset

  logic [PW-1:0] head;                  // oldest entry
  logic [PW-1:0] tail;                  // next free entry
  logic [CW-1:0] count;
  logic [1:0]    push_n;                // entries written this cycle
  logic          pop;

  ////////////////////
  // handshake
  ////////////////////

  assign out_valid = (count != '0);
  assign out_inst  = slots[head].inst;  // steady while not popped
  assign out_pc    = slots[head].pc;
  assign pop       = out_valid && out_ready;

  // under two free entries, a full line could not fit
  assign stall = (count > STALL_AT);

  // slot 1 never pushes alone
  always_comb
  begin
    if (push_valid0 && push_valid1)
      push_n = 2'd2;
    else if (push_valid0)
      push_n = 2'd1;
    else
      push_n = 2'd0;
  end

  ////////////////////
  // storage
  ////////////////////

  always_ff @(posedge clock)
  begin
    if (!flush)
    begin
      if (push_valid0)
        slots[tail] <= '{inst: push_inst0, pc: push_pc0};
      if (push_valid1)
        slots[tail + PW'(1)] <= '{inst: push_inst1, pc: push_pc1};   // wraps with PW bits
    end
  end

  ////////////////////
  // pointers and count
  ////////////////////

  always_ff @(posedge clock)
  begin
    if (reset || flush)
    begin
      head  <= '0;
      tail  <= '0;
      count <= '0;
    end
    else
    begin
      if (pop)
        head <= head + PW'(1);
      tail  <= tail + PW'(push_n);
      count <= count + CW'(push_n) - CW'(pop);
    end
  end

endmodule

`default_nettype wire

// ==== logic/branch_predecode.sv ====
// static predecode only: jumps taken, backward branches taken, no history kept
`default_nettype none

module branch_predecode (
  input  wire fetch_pkg::inst_t inst0,
  input  wire fetch_pkg::inst_t inst1,
  input  wire fetch_pkg::pc_t   pc0,
  input  wire fetch_pkg::pc_t   pc1,
  input  wire logic             slot1_live,
  output logic                  pred_taken0,
  output logic                  pred_taken1,
  output fetch_pkg::pc_t        pred_target0,
  output fetch_pkg::pc_t        pred_target1
);

  localparam int unsigned DW = fetch_pkg::DISP_W;

  fetch_pkg::opcode_t op0;        // slot opcodes
  fetch_pkg::opcode_t op1;
  logic [DW-1:0]      disp0;      // raw displacement fields
  logic [DW-1:0]      disp1;

  ////////////////////
  // helpers
  ////////////////////

  // direction from opcode and displacement sign
  function automatic logic is_taken(input fetch_pkg::opcode_t op, input logic [DW-1:0] disp);
    logic taken;
    case (op)
      fetch_pkg::op_jump:   taken = 1'b1;          // always
      fetch_pkg::op_branch: taken = disp[DW-1];    // backward only
      default:              taken = 1'b0;          // alu, noop and unknown codes
    endcase
    return taken;
  endfunction

  // slot pc + 4 + 4 * sext(disp)
  function automatic fetch_pkg::pc_t target_of(input fetch_pkg::pc_t pc,
                                               input logic [DW-1:0] disp);
    fetch_pkg::pc_t offset;
    offset = {{(64 - DW - 2){disp[DW-1]}}, disp, 2'b00};
    return pc + 64'd4 + offset;
  endfunction

  ////////////////////
  // field extraction
  ////////////////////

  assign op0   = fetch_pkg::opcode_t'(inst0[fetch_pkg::OPC_HI:fetch_pkg::OPC_LO]);
  assign op1   = fetch_pkg::opcode_t'(inst1[fetch_pkg::OPC_HI:fetch_pkg::OPC_LO]);
  assign disp0 = inst0[fetch_pkg::DISP_HI:fetch_pkg::DISP_LO];
  assign disp1 = inst1[fetch_pkg::DISP_HI:fetch_pkg::DISP_LO];

  ////////////////////
  // predictions
  ////////////////////

  assign pred_taken0  = is_taken(op0, disp0);
  assign pred_taken1  = slot1_live && is_taken(op1, disp1);   // padding never predicts
  assign pred_target0 = target_of(pc0, disp0);
  assign pred_target1 = target_of(pc1, disp1);

endmodule

`default_nettype wire

// ==== logic/fetch_stage.sv ====
// PC register and line alignment; only redirect_valid overrides a stall, predictions do not
`default_nettype none

`include "fetch_params.svh"

module fetch_stage (
  input  wire logic             clock,
  input  wire logic             reset,
  input  wire logic             stall,           // queue nearly full
  input  wire logic             redirect_valid,  // mispredict from the resolving stage
  input  wire fetch_pkg::pc_t   redirect_pc,
  input  wire fetch_pkg::line_t mem_data,
  input  wire logic             mem_valid,
  input  wire logic             pred_taken0,
  input  wire logic             pred_taken1,
  input  wire fetch_pkg::pc_t   pred_target0,
  input  wire fetch_pkg::pc_t   pred_target1,
  output fetch_pkg::pc_t        mem_addr,
  output fetch_pkg::inst_t      inst0,
  output fetch_pkg::inst_t      inst1,
  output fetch_pkg::pc_t        pc0,
  output fetch_pkg::pc_t        pc1,
  output logic                  slot1_live,
  output logic                  push_valid0,
  output logic                  push_valid1
);

  fetch_pkg::pc_t pc_reg;        // address being fetched this cycle
  fetch_pkg::pc_t pc_plus_4;
  fetch_pkg::pc_t pc_plus_8;
  fetch_pkg::pc_t next_pc;
  logic           pc_en;
  logic           fetch_ok;      // line usable and queue has room

  ////////////////////
  // alignment
  ////////////////////

  assign mem_addr = {pc_reg[63:3], 3'b000};   // whole-line address

  // pc[2] set: upper word moves to slot 0, slot 1 padded
  assign inst0 = pc_reg[2] ? mem_data[63:32] : mem_data[31:0];
  assign inst1 = pc_reg[2] ? `NOOP_INST : mem_data[63:32];

  assign pc_plus_4 = pc_reg + 64'd4;
  assign pc_plus_8 = pc_reg + 64'd8;

  assign pc0        = pc_reg;
  assign pc1        = pc_plus_4;      // meaningless when slot 1 is padding
  assign slot1_live = !pc_reg[2];

  ////////////////////
  // next pc
  ////////////////////

  // redirect first, then slot 0 then slot 1 predictions, then sequential
  always_comb
  begin
    if (redirect_valid)
      next_pc = redirect_pc;
    else if (pred_taken0)
      next_pc = pred_target0;
    else if (slot1_live && pred_taken1)
      next_pc = pred_target1;
    else if (pc_reg[2])
      next_pc = pc_plus_4;            // odd word, only one slot used
    else
      next_pc = pc_plus_8;
  end

  assign fetch_ok = mem_valid && !stall;
  assign pc_en    = fetch_ok || redirect_valid;   // a held prediction is recomputed next cycle

  always_ff @(posedge clock)
  begin
    if (reset)
      pc_reg <= '0;                   // fetch starts at 0
    else if (pc_en)
      pc_reg <= next_pc;
  end

  ////////////////////
  // push valids
  ////////////////////

  assign push_valid0 = fetch_ok;
  // slot 1 dies behind a taken slot 0 or when it is padding
  assign push_valid1 = fetch_ok && slot1_live && !pred_taken0;

endmodule

`default_nettype wire

// ==== logic/instr_mem.sv ====
// line store without reset, filled only through the load port; read is combinational, no latency
`default_nettype none

`include "fetch_params.svh"

module instr_mem (
  input  wire logic                           clock,
  input  wire logic                           reset,
  input  wire logic                           load_en,
  input  wire logic [$clog2(`IMEM_LINES)-1:0] load_addr,
  input  wire fetch_pkg::line_t               load_data,
  input  wire fetch_pkg::pc_t                 mem_addr,
  output fetch_pkg::line_t                    mem_data,
  output logic                                mem_valid
);

  localparam int AW = $clog2(`IMEM_LINES);   // line index width

  fetch_pkg::line_t lines [`IMEM_LINES];     // the store itself
  logic [AW-1:0]    rd_index;                // line picked by the fetch address
  logic             load_q;                  // load port was busy last cycle

  ////////////////////
  // write side
  ////////////////////

  // one line per edge from the load port
  always_ff @(posedge clock)
  begin
    if (load_en)
      lines[load_addr] <= load_data;
  end

  // guard cycle after a load burst, reads resume once the port goes quiet
  always_ff @(posedge clock)
  begin
    if (reset)
      load_q <= 1'b0;
    else
      load_q <= load_en;
  end

  ////////////////////
  // read side
  ////////////////////

  // byte address -> line index, upper bits wrap
  assign rd_index = mem_addr[3 +: AW];

  assign mem_data  = lines[rd_index];        // same-cycle read
  assign mem_valid = !load_en && !load_q;    // nothing served while loading

endmodule

`default_nettype wire

// ==== logic/fetch_pkg.sv ====
// shared fetch types; opcode values must stay in step with NOOP_INST in fetch_params.svh
`default_nettype none

`include "fetch_params.svh"

package fetch_pkg;

  ////////////////////
  // basic words
  ////////////////////

  typedef logic [63:0] pc_t;                      // byte address
  typedef logic [31:0] inst_t;                    // one instruction
  typedef logic [`FETCH_WIDTH*32-1:0] line_t;     // one memory line, slot 0 in the low word

  ////////////////////
  // instruction fields
  ////////////////////

  localparam int unsigned OPC_HI  = 31;           // opcode field
  localparam int unsigned OPC_LO  = 26;
  localparam int unsigned DISP_HI = 20;           // signed word displacement
  localparam int unsigned DISP_LO = 0;
  localparam int unsigned DISP_W  = DISP_HI - DISP_LO + 1;

  // top six bits; anything not listed behaves like op_alu
  typedef enum logic [5:0] {
    op_alu    = 6'h10,
    op_jump   = 6'h30,
    op_branch = 6'h39,
    op_noop   = 6'h1f
  } opcode_t;

  ////////////////////
  // queue entry
  ////////////////////

  typedef struct packed {
    inst_t inst;    // instruction word
    pc_t   pc;      // its own address
  } qslot_t;

endpackage

`default_nettype wire

// ==== logic/fetch_params.svh ====
// fetch front end sizes; the line is fixed at 64 bits and QUEUE_DEPTH must be a power of two
`ifndef FETCH_PARAMS_SVH
`define FETCH_PARAMS_SVH

////////////////////
// line geometry
////////////////////

// instructions per 64-bit line, tied to the line width
`define FETCH_WIDTH 2

// lines in the instruction store, index wraps modulo this
`define IMEM_LINES 256

////////////////////
// queue sizing
////////////////////

// fetch queue entries (4, 8 or 16 all work)
`define QUEUE_DEPTH 8

////////////////////
// encodings
////////////////////

// no-op word, opcode field 6'h1f and all other bits zero
// must agree with fetch_pkg::op_noop
`define NOOP_INST 32'h7c00_0000

`endif
